//--- design/fir_params.svh
// fixed 11-tap configuration; tap addresses assume 32-bit words on a 12-bit AXI-Lite map
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// datapath and bus widths
`define FIR_DATA_W 32
`define FIR_ADDR_W 12
`define FIR_TAP_IDX_W 4

// filter length, fixed at build time
`define FIR_NUM_TAPS 11

// register map
`define FIR_ADDR_CTRL 12'h000
`define FIR_ADDR_LEN  12'h010
`define FIR_ADDR_TAP0 12'h080

// ap_ctrl bit positions
`define FIR_CTRL_START 0
`define FIR_CTRL_DONE  1
`define FIR_CTRL_IDLE  2

// returned for tap reads while the engine runs
`define FIR_BUSY_RDATA 32'hFFFF_FFFF

`endif

//--- design/fir_pkg.sv
// shared vector types and the ap state encoding; widths follow fir_params.svh
`default_nettype none

`include "fir_params.svh"

package fir_pkg;

  // one sample, tap coefficient or accumulated result
  typedef logic [`FIR_DATA_W-1:0] sample_t;

  // AXI-Lite byte address
  typedef logic [`FIR_ADDR_W-1:0] lite_addr_t;

  // index into the tap register file and delay line
  typedef logic [`FIR_TAP_IDX_W-1:0] tap_idx_t;

  // number of outputs in a run
  typedef logic [`FIR_DATA_W-1:0] count_t;

  // host-visible engine state
  typedef enum logic [1:0] {
    AP_IDLE = 2'd0,
    AP_RUN  = 2'd1,
    AP_DONE = 2'd2
  } ap_state_t;

endpackage

`default_nettype wire

//--- design/reg_decode.sv
// AXI-Lite slave without bresp; taps and data_length are frozen while ap_ctrl shows start
`default_nettype none

`include "fir_params.svh"

module reg_decode (
  input  wire                      axis_clk,
  input  wire                      axis_rst_n,
  input  wire                      awvalid,
  input  wire fir_pkg::lite_addr_t awaddr,
  output logic                     awready,
  input  wire                      wvalid,
  input  wire fir_pkg::sample_t    wdata,
  output logic                     wready,
  input  wire                      arvalid,
  input  wire fir_pkg::lite_addr_t araddr,
  output logic                     arready,
  output logic                     rvalid,
  output fir_pkg::sample_t         rdata,
  input  wire                      rready,
  input  wire                      run_finish,
  input  wire fir_pkg::tap_idx_t   tap_idx,
  output logic                     run_start,
  output logic                     running,
  output fir_pkg::count_t          data_length,
  output fir_pkg::sample_t         tap_coef
);

  import fir_pkg::*;

  ap_state_t  ap_state;
  sample_t    taps [`FIR_NUM_TAPS];
  logic       wr_en;
  logic       rd_take;
  logic       rd_clr_done;
  logic [2:0] ctrl_rd;
  sample_t    rd_value;

  // address falls on one of the tap words
  function automatic logic is_tap(lite_addr_t addr);
    lite_addr_t off;
    off = addr - `FIR_ADDR_TAP0;
    return (addr >= `FIR_ADDR_TAP0) && (off[1:0] == 2'b00) &&
           (off[`FIR_ADDR_W-1:2] < `FIR_NUM_TAPS);
  endfunction

  function automatic tap_idx_t tap_of(lite_addr_t addr);
    lite_addr_t off;
    off = addr - `FIR_ADDR_TAP0;
    return off[`FIR_TAP_IDX_W+1:2];
  endfunction

  // write channel, address and data accepted on the same edge
  assign wr_en = awready && awvalid && wvalid;
  assign wready = awready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      awready <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !awready;
    end
  end

  assign run_start = wr_en && (awaddr == `FIR_ADDR_CTRL) &&
                     wdata[`FIR_CTRL_START] && (ap_state == AP_IDLE);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      data_length <= '0;
      for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
        taps[k] <= '0;
      end
    end else if (wr_en && (ap_state != AP_RUN)) begin
      // length also held, the output counter compares against it live
      if (awaddr == `FIR_ADDR_LEN) begin
        data_length <= wdata;
      end
      if (is_tap(awaddr)) begin
        taps[tap_of(awaddr)] <= wdata;
      end
    end
  end

  // combinational tap lookup for the MAC
  assign tap_coef = (tap_idx < `FIR_NUM_TAPS) ? taps[tap_idx] : '0;

  // ap_ctrl as seen by the host
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[`FIR_CTRL_START] = (ap_state == AP_RUN);
    ctrl_rd[`FIR_CTRL_DONE]  = (ap_state == AP_DONE);
    ctrl_rd[`FIR_CTRL_IDLE]  = (ap_state != AP_RUN);
  end

  always_comb begin
    rd_value = '0;
    if (araddr == `FIR_ADDR_CTRL) begin
      rd_value = sample_t'(ctrl_rd);
    end else if (araddr == `FIR_ADDR_LEN) begin
      rd_value = data_length;
    end else if (is_tap(araddr)) begin
      rd_value = (ap_state == AP_RUN) ? `FIR_BUSY_RDATA : taps[tap_of(araddr)];
    end
  end

  // read channel, data captured on the address handshake
  assign rd_take = arvalid && arready;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      arready     <= 1'b0;
      rvalid      <= 1'b0;
      rd_clr_done <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_take) begin
        rvalid      <= 1'b1;
        rd_clr_done <= (araddr == `FIR_ADDR_CTRL) && (ap_state == AP_DONE);
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (rd_take) begin
      rdata <= rd_value;
    end
  end

  // ap FSM
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ap_state <= AP_IDLE;
    end else begin
      case (ap_state)
        AP_IDLE: begin
          if (run_start) begin
            ap_state <= AP_RUN;
          end
        end
        AP_RUN: begin
          if (run_finish) begin
            ap_state <= AP_DONE;
          end
        end
        AP_DONE: begin
          // done only clears once the host has seen it
          if (rvalid && rready && rd_clr_done) begin
            ap_state <= AP_IDLE;
          end
        end
        default: begin
          ap_state <= AP_IDLE;
        end
      endcase
    end
  end

  assign running = (ap_state == AP_RUN);

  a_awready_pulse : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    awready |=> !awready)
    else $error("awready held for two cycles");

  a_start_from_idle : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    run_start |-> (ap_state == AP_IDLE) ##1 running)
    else $error("run_start outside idle or run did not begin");

endmodule

`default_nettype wire

//--- design/tap_mac.sv
// one sample in flight; a finished sum waits here while the output register is full
`default_nettype none

`include "fir_params.svh"

module tap_mac (
  input  wire                    axis_clk,
  input  wire                    axis_rst_n,
  input  wire                    ss_tvalid,
  input  wire fir_pkg::sample_t  ss_tdata,
  input  wire                    ss_tlast,
  output logic                   ss_tready,
  input  wire                    run_start,
  input  wire                    running,
  input  wire fir_pkg::sample_t  tap_coef,
  input  wire                    hold_full,
  output fir_pkg::tap_idx_t      tap_idx,
  output logic                   y_valid,
  output fir_pkg::sample_t       y_sum
);

  import fir_pkg::*;

  // delay_q[k] holds x[n-k]
  sample_t delay_q [`FIR_NUM_TAPS];
  sample_t acc;
  sample_t product;
  logic    busy;
  logic    pend;
  logic    last_seen;
  logic    ss_fire;
  logic    last_tap;

  // hold_full blocks input so back-pressure reaches the source
  assign ss_tready = running && !busy && !last_seen && !hold_full;
  assign ss_fire   = ss_tvalid && ss_tready;
  assign last_tap  = busy && (tap_idx == tap_idx_t'(`FIR_NUM_TAPS - 1));

  // wrapping 32-bit product
  assign product = delay_q[tap_idx] * tap_coef;

  // result leaves only when the output register can take it
  assign y_valid = pend && !hold_full;
  assign y_sum   = acc;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      busy      <= 1'b0;
      pend      <= 1'b0;
      last_seen <= 1'b0;
      tap_idx   <= '0;
    end else if (run_start) begin
      busy      <= 1'b0;
      pend      <= 1'b0;
      last_seen <= 1'b0;
      tap_idx   <= '0;
    end else begin
      if (y_valid) begin
        pend <= 1'b0;
      end
      if (ss_fire) begin
        busy    <= 1'b1;
        tap_idx <= '0;
        // no more input until the next start
        if (ss_tlast) begin
          last_seen <= 1'b1;
        end
      end else if (last_tap) begin
        busy    <= 1'b0;
        pend    <= 1'b1;
        tap_idx <= '0;
      end else if (busy) begin
        tap_idx <= tap_idx + 1'b1;
      end
    end
  end

  // sample history and accumulator
  always_ff @(posedge axis_clk) begin
    if (run_start) begin
      // zero history for a fresh run
      for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
        delay_q[k] <= '0;
      end
    end else if (ss_fire) begin
      delay_q[0] <= ss_tdata;
      for (int k = 1; k < `FIR_NUM_TAPS; k++) begin
        delay_q[k] <= delay_q[k-1];
      end
    end
    if (ss_fire) begin
      acc <= '0;
    end else if (busy) begin
      acc <= acc + product;
    end
  end

  // input stays closed for the whole accumulation
  a_no_accept_while_busy : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    ss_fire |=> !ss_tready [*`FIR_NUM_TAPS])
    else $error("ss_tready raised during accumulation");

endmodule

`default_nettype wire

//--- design/stream_result.sv
// single-entry output register; sm_tlast never rises if data_length is zero
`default_nettype none

module stream_result (
  input  wire                   axis_clk,
  input  wire                   axis_rst_n,
  input  wire                   y_valid,
  input  wire fir_pkg::sample_t y_sum,
  input  wire                   sm_tready,
  input  wire                   run_start,
  input  wire fir_pkg::count_t  data_length,
  output logic                  sm_tvalid,
  output fir_pkg::sample_t      sm_tdata,
  output logic                  sm_tlast,
  output logic                  hold_full,
  output logic                  run_finish
);

  import fir_pkg::*;

  // completed transfers this run
  count_t out_cnt;
  count_t cnt_next;
  logic   sm_fire;

  assign sm_fire  = sm_tvalid && sm_tready;
  assign cnt_next = out_cnt + 1'b1;

  // offered word is the data_length-th
  assign sm_tlast   = sm_tvalid && (cnt_next == data_length);
  assign run_finish = sm_fire && sm_tlast;

  // register occupied until the sink takes it
  assign hold_full = sm_tvalid;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      sm_tvalid <= 1'b0;
      out_cnt   <= '0;
    end else begin
      // y_valid only arrives when the register is empty
      if (y_valid) begin
        sm_tvalid <= 1'b1;
      end else if (sm_fire) begin
        sm_tvalid <= 1'b0;
      end
      if (run_start) begin
        out_cnt <= '0;
      end else if (sm_fire) begin
        out_cnt <= cnt_next;
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (y_valid) begin
      sm_tdata <= y_sum;
    end
  end

  a_hold_stable : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
    else $error("sm_tdata changed while stalled");

endmodule

`default_nettype wire

//--- design/fir_top.sv
// FIR engine top; writes need awvalid and wvalid together, and data_length must be nonzero
`default_nettype none

module fir_top (
  input  wire                     axis_clk,
  input  wire                     axis_rst_n,
  // AXI-Lite write
  input  wire                     awvalid,
  input  wire fir_pkg::lite_addr_t awaddr,
  output logic                    awready,
  input  wire                     wvalid,
  input  wire fir_pkg::sample_t   wdata,
  output logic                    wready,
  // AXI-Lite read
  input  wire                     arvalid,
  input  wire fir_pkg::lite_addr_t araddr,
  output logic                    arready,
  output logic                    rvalid,
  output fir_pkg::sample_t        rdata,
  input  wire                     rready,
  // AXI-Stream input samples
  input  wire                     ss_tvalid,
  input  wire fir_pkg::sample_t   ss_tdata,
  input  wire                     ss_tlast,
  output logic                    ss_tready,
  // AXI-Stream output results
  output logic                    sm_tvalid,
  output fir_pkg::sample_t        sm_tdata,
  output logic                    sm_tlast,
  input  wire                     sm_tready
);

  import fir_pkg::*;

  logic     run_start;
  logic     running;
  logic     run_finish;
  count_t   data_length;
  tap_idx_t tap_idx;
  sample_t  tap_coef;
  logic     y_valid;
  sample_t  y_sum;
  logic     hold_full;

  reg_decode u_decode (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .awready     (awready),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wready      (wready),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rready      (rready),
    .run_finish  (run_finish),
    .tap_idx     (tap_idx),
    .run_start   (run_start),
    .running     (running),
    .data_length (data_length),
    .tap_coef    (tap_coef)
  );

  tap_mac u_execute (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .ss_tlast   (ss_tlast),
    .ss_tready  (ss_tready),
    .run_start  (run_start),
    .running    (running),
    .tap_coef   (tap_coef),
    .hold_full  (hold_full),
    .tap_idx    (tap_idx),
    .y_valid    (y_valid),
    .y_sum      (y_sum)
  );

  stream_result u_result (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .y_valid     (y_valid),
    .y_sum       (y_sum),
    .sm_tready   (sm_tready),
    .run_start   (run_start),
    .data_length (data_length),
    .sm_tvalid   (sm_tvalid),
    .sm_tdata    (sm_tdata),
    .sm_tlast    (sm_tlast),
    .hold_full   (hold_full),
    .run_finish  (run_finish)
  );

endmodule

`default_nettype wire

//--- tb/fir_tb.sv
// FIR testbench; each run's data_length equals its sample count, and the first error ends the run
`default_nettype none

`include "fir_params.svh"

module fir_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fir_pkg::*;

  localparam int RUN1_LEN = 40;
  localparam int RUN2_LEN = 24;
  localparam int TOTAL = RUN1_LEN + RUN2_LEN;
  localparam int WATCHDOG_CYCLES = TOTAL * (`FIR_NUM_TAPS + 4) * 4 + 2000;

  logic       axis_clk;
  logic       axis_rst_n;
  logic       awvalid;
  lite_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  sample_t    wdata;
  logic       wready;
  logic       arvalid;
  lite_addr_t araddr;
  logic       arready;
  logic       rvalid;
  sample_t    rdata;
  logic       rready;
  logic       ss_tvalid;
  sample_t    ss_tdata;
  logic       ss_tlast;
  logic       ss_tready;
  logic       sm_tvalid;
  sample_t    sm_tdata;
  logic       sm_tlast;
  logic       sm_tready;

  // reference model state
  sample_t h [`FIR_NUM_TAPS];
  sample_t x_mem [TOTAL];
  sample_t exp_y [TOTAL];
  int      out_idx;
  int      run_end;
  integer  seed;

  // host is asking for a start on the write channel
  wire start_wr = awvalid && wvalid && (awaddr == `FIR_ADDR_CTRL) && wdata[`FIR_CTRL_START];

  fir_top DUT (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wready     (wready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rready     (rready),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .ss_tlast   (ss_tlast),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .sm_tready  (sm_tready)
  );

  initial begin
    axis_clk = 1'b0;
    forever #20 axis_clk = ~axis_clk;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic mismatch(input string name, input sample_t got, input sample_t expected);
    report_failure($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected));
  endtask

  task automatic lite_write(input lite_addr_t addr, input sample_t data);
    @(posedge axis_clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    do @(negedge axis_clk); while (!awready);
    @(posedge axis_clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
  endtask

  task automatic lite_read(input lite_addr_t addr, output sample_t data);
    @(posedge axis_clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do @(negedge axis_clk); while (!arready);
    @(posedge axis_clk);
    arvalid <= 1'b0;
    do @(negedge axis_clk); while (!rvalid);
    data = rdata;
    @(posedge axis_clk);
    rready <= 1'b0;
  endtask

  task automatic expect_read(input lite_addr_t addr, input sample_t expected);
    sample_t got;
    lite_read(addr, got);
    assert (got == expected)
      else mismatch($sformatf("rdata@0x%03h", addr), got, expected);
  endtask

  // y[n] = sum h[k] * x[n-k] with a zero history at the run start
  task automatic build_expected(input int base, input int n);
    sample_t acc;
    for (int i = 0; i < n; i++) begin
      acc = '0;
      for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
        if (i - k >= 0) begin
          acc = acc + h[k] * x_mem[base + i - k];
        end
      end
      exp_y[base + i] = acc;
    end
  endtask

  task automatic send_samples(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge axis_clk);
      ss_tvalid <= 1'b1;
      ss_tdata  <= x_mem[base + i];
      ss_tlast  <= (i == n - 1);
      do @(negedge axis_clk); while (!ss_tready);
    end
    @(posedge axis_clk);
    ss_tvalid <= 1'b0;
    ss_tlast  <= 1'b0;
  endtask

  // random back-pressure with ready about three cycles in four
  task automatic sink_outputs(input int target);
    while (out_idx < target) begin
      @(posedge axis_clk);
      sm_tready <= (($random(seed) & 3) != 0);
      @(negedge axis_clk);
    end
    @(posedge axis_clk);
    sm_tready <= 1'b0;
  endtask

  task automatic run_filter(input int base, input int n, input bit probe_taps);
    build_expected(base, n);
    run_end = base + n;
    lite_write(`FIR_ADDR_LEN, sample_t'(n));
    lite_write(`FIR_ADDR_CTRL, sample_t'(1 << `FIR_CTRL_START));
    fork
      send_samples(base, n);
      sink_outputs(base + n);
      if (probe_taps) begin
        // tap port is locked mid-run
        repeat (30) @(posedge axis_clk);
        expect_read(lite_addr_t'(`FIR_ADDR_TAP0 + 12), `FIR_BUSY_RDATA);
        lite_write(lite_addr_t'(`FIR_ADDR_TAP0 + 12), 32'h1234_5678);
      end
    join
    // done and idle, then idle alone once done is seen
    expect_read(`FIR_ADDR_CTRL, 32'h6);
    expect_read(`FIR_ADDR_CTRL, 32'h4);
  endtask

  always @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      out_idx <= 0;
    end else if (sm_tvalid && sm_tready) begin
      out_idx <= out_idx + 1;
    end
  end

  a_w_ready : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    wready == awready)
    else mismatch("wready", $sampled(wready), $sampled(awready));

  a_out_data : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && sm_tready |-> sm_tdata == exp_y[out_idx])
    else mismatch("sm_tdata", $sampled(sm_tdata), exp_y[$sampled(out_idx)]);

  a_out_last : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && sm_tready |-> sm_tlast == (out_idx == run_end - 1))
    else mismatch("sm_tlast", $sampled(sm_tlast), $sampled(out_idx) == run_end - 1);

  a_out_stall : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
    else report_failure("sm_tdata or sm_tvalid changed while the output was stalled");

  a_in_closed : assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    ss_tvalid && ss_tready && ss_tlast |=> !ss_tready until start_wr)
    else report_failure("ss_tready rose after ss_tlast before the next start");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge axis_clk);
    report_failure("timeout, the filter runs did not complete in time");
  end

  initial begin
    axis_rst_n <= 1'b0;
    awvalid    <= 1'b0;
    awaddr     <= '0;
    wvalid     <= 1'b0;
    wdata      <= '0;
    arvalid    <= 1'b0;
    araddr     <= '0;
    rready     <= 1'b0;
    ss_tvalid  <= 1'b0;
    ss_tdata   <= '0;
    ss_tlast   <= 1'b0;
    sm_tready  <= 1'b0;
    run_end    = 0;
    seed       = 32'h8b6dbc5d;
    repeat (5) @(posedge axis_clk);
    axis_rst_n <= 1'b1;
    @(negedge axis_clk);
    assert (!sm_tvalid) else mismatch("sm_tvalid", sm_tvalid, 0);
    assert (!ss_tready) else mismatch("ss_tready", ss_tready, 0);
    expect_read(`FIR_ADDR_CTRL, 32'h4);
    // configuration readback while idle
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      h[k] = $random(seed);
      lite_write(lite_addr_t'(`FIR_ADDR_TAP0 + 4 * k), h[k]);
    end
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      expect_read(lite_addr_t'(`FIR_ADDR_TAP0 + 4 * k), h[k]);
    end
    lite_write(`FIR_ADDR_LEN, 32'h0000_1357);
    expect_read(`FIR_ADDR_LEN, 32'h0000_1357);
    for (int i = 0; i < TOTAL; i++) begin
      x_mem[i] = $random(seed);
    end
    run_filter(0, RUN1_LEN, 1'b1);
    // the write during the run must not have landed
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
      expect_read(lite_addr_t'(`FIR_ADDR_TAP0 + 4 * k), h[k]);
    end
    run_filter(RUN1_LEN, RUN2_LEN, 1'b0);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/fir_pkg.sv
design/reg_decode.sv
design/tap_mac.sv
design/stream_result.sv
design/fir_top.sv
tb/fir_tb.sv
